//--- hdl/ex_pkg.sv
package ex_pkg;

    localparam int XLEN         = 64;
    localparam int ILEN         = 32;
    localparam int REG_ADDR_W   = 5;
    localparam int WMASK_W      = XLEN / 8;    // one enable per byte lane
    localparam int SHAMT_W      = 6;
    localparam int SHAMT_W_WORD = SHAMT_W - 1;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [ILEN-1:0]       inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [WMASK_W-1:0]    wmask_t;
    typedef logic [6:0]            opcode_t;
    typedef logic [2:0]            funct3_t;
    typedef logic [6:0]            funct7_t;

    // major opcodes, RV64I subset
    localparam opcode_t OPC_OP_IMM   = 7'b0010011;
    localparam opcode_t OPC_OP_IMM_W = 7'b0011011;
    localparam opcode_t OPC_OP       = 7'b0110011;
    localparam opcode_t OPC_OP_W     = 7'b0111011;
    localparam opcode_t OPC_BRANCH   = 7'b1100011;
    localparam opcode_t OPC_LOAD     = 7'b0000011;
    localparam opcode_t OPC_STORE    = 7'b0100011;
    localparam opcode_t OPC_JAL      = 7'b1101111;
    localparam opcode_t OPC_JALR     = 7'b1100111;
    localparam opcode_t OPC_LUI      = 7'b0110111;
    localparam opcode_t OPC_AUIPC    = 7'b0010111;

    // integer ops, same for reg and imm forms
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;  // srl / sra
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct3_t F3_SB   = 3'b000;
    localparam funct3_t F3_SH   = 3'b001;
    localparam funct3_t F3_SW   = 3'b010;
    localparam funct3_t F3_SD   = 3'b011;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;  // sub / sra

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B   // lui, immediate already in op2
    } alu_op_e;

endpackage

//--- hdl/ex_decode.sv
module ex_decode
    import ex_pkg::*;
(
    input  inst_t   inst_i,
    output alu_op_e alu_op_o,
    output logic    is_word_o,
    output logic    rd_write_o,
    output logic    is_branch_o,
    output logic    is_jump_o,
    output logic    is_load_o,
    output logic    is_store_o
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    is_reg;      // register-register form
    logic    f7_ok;
    logic    word_f3_ok;
    alu_op_e f3_op;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign is_reg = (opcode == OPC_OP) || (opcode == OPC_OP_W);

    // alt funct7 only legal on add/sub and the right shifts
    assign f7_ok = (funct7 == F7_BASE)
                || ((funct7 == F7_ALT) && ((funct3 == F3_ADD) || (funct3 == F3_SR)));
    assign word_f3_ok = (funct3 == F3_ADD) || (funct3 == F3_SLL) || (funct3 == F3_SR);

    always_comb begin
        case (funct3)
            F3_ADD:  f3_op = (is_reg && funct7[5]) ? ALU_SUB : ALU_ADD;
            F3_SLL:  f3_op = ALU_SLL;
            F3_SLT:  f3_op = ALU_SLT;
            F3_SLTU: f3_op = ALU_SLTU;
            F3_XOR:  f3_op = ALU_XOR;
            F3_SR:   f3_op = funct7[5] ? ALU_SRA : ALU_SRL;  // imm shifts use it too
            F3_OR:   f3_op = ALU_OR;
            default: f3_op = ALU_AND;
        endcase
    end

    always_comb begin
        alu_op_o    = ALU_ADD;
        is_word_o   = 1'b0;
        rd_write_o  = 1'b0;
        is_branch_o = 1'b0;
        is_jump_o   = 1'b0;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                alu_op_o   = f3_op;
                rd_write_o = 1'b1;
            end
            OPC_OP_IMM_W: begin
                if (word_f3_ok) begin
                    alu_op_o   = f3_op;
                    is_word_o  = 1'b1;
                    rd_write_o = 1'b1;
                end
            end
            OPC_OP: begin
                if (f7_ok) begin
                    alu_op_o   = f3_op;
                    rd_write_o = 1'b1;
                end
            end
            OPC_OP_W: begin
                if (f7_ok && word_f3_ok) begin
                    alu_op_o   = f3_op;
                    is_word_o  = 1'b1;
                    rd_write_o = 1'b1;
                end
            end
            OPC_LUI: begin
                alu_op_o   = ALU_PASS_B;
                rd_write_o = 1'b1;
            end
            OPC_AUIPC: rd_write_o = 1'b1;   // op1 + op2
            OPC_JAL, OPC_JALR: begin
                rd_write_o = 1'b1;              // link value pc + 4
                is_jump_o  = 1'b1;
            end
            OPC_BRANCH: is_branch_o = 1'b1;
            OPC_LOAD: begin
                // 3'b111 has no load on rv64
                if (funct3 != 3'b111) begin
                    is_load_o  = 1'b1;
                    rd_write_o = 1'b1;
                end
            end
            OPC_STORE: is_store_o = 1'b1;
            default: ;
        endcase
    end

endmodule

//--- hdl/ex_alu.sv
module ex_alu
    import ex_pkg::*;
(
    input  alu_op_e alu_op_i,
    input  logic    is_word_i,
    input  xlen_t   op1_i,
    input  xlen_t   op2_i,
    input  xlen_t   base_addr_i,
    input  xlen_t   offset_addr_i,
    output xlen_t   result_o,
    output xlen_t   agu_addr_o
);

    logic [SHAMT_W-1:0]      shamt;
    logic [SHAMT_W_WORD-1:0] shamt_word;
    xlen_t                   full_res;
    logic [31:0]             word_res;

    assign shamt_word = op2_i[SHAMT_W_WORD-1:0];
    // word forms only look at 5 bits of the shift amount
    assign shamt = is_word_i ? {1'b0, shamt_word} : op2_i[SHAMT_W-1:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    full_res = op1_i + op2_i;
            ALU_SUB:    full_res = op1_i - op2_i;
            ALU_SLL:    full_res = op1_i << shamt;
            ALU_SLT:    full_res = {{(XLEN-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
            ALU_SLTU:   full_res = {{(XLEN-1){1'b0}}, op1_i < op2_i};
            ALU_XOR:    full_res = op1_i ^ op2_i;
            ALU_SRL:    full_res = op1_i >> shamt;
            ALU_SRA:    full_res = $signed(op1_i) >>> shamt;
            ALU_OR:     full_res = op1_i | op2_i;
            ALU_AND:    full_res = op1_i & op2_i;
            ALU_PASS_B: full_res = op2_i;
            default:    full_res = '0;
        endcase
    end

    // right shifts must bring in bits from bit 31, not bit 63
    always_comb begin
        case (alu_op_i)
            ALU_SRL: word_res = op1_i[31:0] >> shamt_word;
            ALU_SRA: word_res = $signed(op1_i[31:0]) >>> shamt_word;
            default: word_res = full_res[31:0];  // add/sub/sll low half is already right
        endcase
    end

    assign result_o = is_word_i ? {{32{word_res[31]}}, word_res} : full_res;

    // branch / jump target and load-store address
    assign agu_addr_o = base_addr_i + offset_addr_i;

endmodule

//--- hdl/ex_branch.sv
module ex_branch
    import ex_pkg::*;
(
    input  logic    is_branch_i,
    input  logic    is_jump_i,
    input  funct3_t funct3_i,
    input  xlen_t   op1_i,
    input  xlen_t   op2_i,
    input  xlen_t   agu_addr_i,
    output logic    jump_en_o,
    output xlen_t   jump_addr_o
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic taken;

    assign eq   = (op1_i == op2_i);
    assign lt_s = ($signed(op1_i) < $signed(op2_i));
    assign lt_u = (op1_i < op2_i);

    always_comb begin
        taken = 1'b0;
        if (is_branch_i) begin
            case (funct3_i)
                F3_BEQ:  taken = eq;
                F3_BNE:  taken = ~eq;
                F3_BLT:  taken = lt_s;
                F3_BGE:  taken = ~lt_s;
                F3_BLTU: taken = lt_u;
                F3_BGEU: taken = ~lt_u;
                default: taken = 1'b0;  // 010 / 011 undefined
            endcase
        end
    end

    assign jump_en_o   = is_jump_i | taken;  // jal / jalr unconditional
    assign jump_addr_o = jump_en_o ? agu_addr_i : '0;

endmodule

//--- hdl/ex_lsu_req.sv
module ex_lsu_req
    import ex_pkg::*;
(
    input  logic    is_load_i,
    input  logic    is_store_i,
    input  funct3_t funct3_i,
    input  xlen_t   op2_i,
    input  xlen_t   agu_addr_i,
    output logic    mem_ren_o,
    output logic    mem_wen_o,
    output xlen_t   mem_addr_o,
    output xlen_t   mem_wdata_o,
    output wmask_t  mem_wmask_o
);

    // load width and sign are handled after the memory returns data
    assign mem_ren_o = is_load_i;

    always_comb begin
        mem_wen_o   = 1'b0;
        mem_wdata_o = '0;
        mem_wmask_o = '0;
        if (is_store_i) begin
            case (funct3_i)
                F3_SB: begin
                    mem_wen_o   = 1'b1;
                    mem_wdata_o = xlen_t'(op2_i[7:0]);
                    mem_wmask_o = wmask_t'(8'b0000_0001);
                end
                F3_SH: begin
                    mem_wen_o   = 1'b1;
                    mem_wdata_o = xlen_t'(op2_i[15:0]);
                    mem_wmask_o = wmask_t'(8'b0000_0011);
                end
                F3_SW: begin
                    mem_wen_o   = 1'b1;
                    mem_wdata_o = xlen_t'(op2_i[31:0]);
                    mem_wmask_o = wmask_t'(8'b0000_1111);
                end
                F3_SD: begin
                    mem_wen_o   = 1'b1;
                    mem_wdata_o = op2_i;
                    mem_wmask_o = '1;
                end
                default: ;
            endcase
        end
    end

    assign mem_addr_o = (mem_ren_o | mem_wen_o) ? agu_addr_i : '0;

endmodule

//--- hdl/ex_stage.sv
module ex_stage
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      valid_i,
    input  inst_t     inst_i,
    input  xlen_t     pc_i,
    input  xlen_t     op1_i,
    input  xlen_t     op2_i,
    input  xlen_t     base_addr_i,
    input  xlen_t     offset_addr_i,
    input  reg_addr_t rd_addr_i,
    output logic      valid_o,
    output xlen_t     pc_o,
    output xlen_t     rd_wdata_o,
    output reg_addr_t rd_waddr_o,
    output logic      reg_wen_o,
    output logic      jump_en_o,
    output xlen_t     jump_addr_o,
    output logic      mem_ren_o,
    output logic      mem_wen_o,
    output xlen_t     mem_addr_o,
    output xlen_t     mem_wdata_o,
    output wmask_t    mem_wmask_o
);

    funct3_t funct3;
    alu_op_e alu_op;
    logic    is_word;
    logic    rd_write;
    logic    is_branch;
    logic    is_jump;
    logic    is_load;
    logic    is_store;
    xlen_t   alu_result;
    xlen_t   agu_addr;
    logic    jump_en;
    xlen_t   jump_addr;
    logic    mem_ren;
    logic    mem_wen;
    xlen_t   mem_addr;
    xlen_t   mem_wdata;
    wmask_t  mem_wmask;

    assign funct3 = inst_i[14:12];

    ex_decode u_decode (
        .inst_i      (inst_i),
        .alu_op_o    (alu_op),
        .is_word_o   (is_word),
        .rd_write_o  (rd_write),
        .is_branch_o (is_branch),
        .is_jump_o   (is_jump),
        .is_load_o   (is_load),
        .is_store_o  (is_store)
    );

    ex_alu u_alu (
        .alu_op_i      (alu_op),
        .is_word_i     (is_word),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .base_addr_i   (base_addr_i),
        .offset_addr_i (offset_addr_i),
        .result_o      (alu_result),
        .agu_addr_o    (agu_addr)
    );

    ex_branch u_branch (
        .is_branch_i (is_branch),
        .is_jump_i   (is_jump),
        .funct3_i    (funct3),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .agu_addr_i  (agu_addr),
        .jump_en_o   (jump_en),
        .jump_addr_o (jump_addr)
    );

    ex_lsu_req u_lsu_req (
        .is_load_i   (is_load),
        .is_store_i  (is_store),
        .funct3_i    (funct3),
        .op2_i       (op2_i),
        .agu_addr_i  (agu_addr),
        .mem_ren_o   (mem_ren),
        .mem_wen_o   (mem_wen),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_wmask_o (mem_wmask)
    );

    // ex/mem register, control half qualified by valid_i
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o     <= 1'b0;
            reg_wen_o   <= 1'b0;
            jump_en_o   <= 1'b0;
            mem_ren_o   <= 1'b0;
            mem_wen_o   <= 1'b0;
            mem_wmask_o <= '0;
        end else begin
            valid_o     <= valid_i;
            reg_wen_o   <= valid_i & rd_write;
            jump_en_o   <= valid_i & jump_en;
            mem_ren_o   <= valid_i & mem_ren;
            mem_wen_o   <= valid_i & mem_wen;
            mem_wmask_o <= valid_i ? mem_wmask : '0;
        end
    end

    // payload half, loaded every cycle
    always_ff @(posedge clk) begin
        pc_o        <= pc_i;
        rd_wdata_o  <= (rd_write && !is_load) ? alu_result : '0;  // load data comes from mem
        rd_waddr_o  <= rd_write ? rd_addr_i : '0;
        jump_addr_o <= jump_addr;
        mem_addr_o  <= mem_addr;
        mem_wdata_o <= mem_wdata;
    end

endmodule

//--- tb/ex_stage_asserts.sv
module ex_stage_asserts
    import ex_pkg::*;
(
    input logic   clk,
    input logic   arst_n_i,
    input logic   valid_o,
    input logic   reg_wen_o,
    input logic   jump_en_o,
    input logic   mem_ren_o,
    input logic   mem_wen_o,
    input wmask_t mem_wmask_o
);

    logic any_en;

    assign any_en = reg_wen_o | jump_en_o | mem_ren_o | mem_wen_o;

    // control half of the ex/mem register held clear
    reset_quiet: assert property (@(posedge clk)
        !arst_n_i |-> !valid_o && !any_en && (mem_wmask_o == '0))
        else $error("control outputs active while in reset");

    en_needs_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        any_en |-> valid_o)
        else $error("enable raised without valid_o");

    ren_wen_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(mem_ren_o && mem_wen_o))
        else $error("load and store requested together");

    mask_matches_wen: assert property (@(posedge clk) disable iff (!arst_n_i)
        (mem_wmask_o != '0) == mem_wen_o)
        else $error("byte mask disagrees with mem_wen_o");

endmodule

bind ex_stage ex_stage_asserts u_asserts (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .valid_o     (valid_o),
    .reg_wen_o   (reg_wen_o),
    .jump_en_o   (jump_en_o),
    .mem_ren_o   (mem_ren_o),
    .mem_wen_o   (mem_wen_o),
    .mem_wmask_o (mem_wmask_o)
);

//--- tb/tb_ex_stage.sv
module tb_ex_stage
    import ex_pkg::*;
();

    localparam int          NUM_CYCLES   = 3000;
    localparam int          RESET_CYCLES = 8;
    localparam int          WAIT_LIMIT   = 50;
    localparam logic [31:0] SEED         = 32'd96511;
    // eleven supported opcodes, last one is fence and illegal here
    localparam opcode_t OPC_TABLE [12] = '{OPC_OP_IMM, OPC_OP_IMM_W, OPC_OP, OPC_OP_W,
                                           OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_JAL,
                                           OPC_JALR, OPC_LUI, OPC_AUIPC, 7'b0001111};

    logic      clk;
    logic      arst_n_i;
    logic      valid_i;
    inst_t     inst_i;
    xlen_t     pc_i, op1_i, op2_i, base_addr_i, offset_addr_i;
    reg_addr_t rd_addr_i;
    logic      valid_o, reg_wen_o, jump_en_o, mem_ren_o, mem_wen_o;
    xlen_t     pc_o, rd_wdata_o, jump_addr_o, mem_addr_o, mem_wdata_o;
    reg_addr_t rd_waddr_o;
    wmask_t    mem_wmask_o;

    // model outputs for the instruction in flight
    logic      exp_valid, exp_wen, exp_jen, exp_ren, exp_men;
    xlen_t     exp_pc, exp_wdata, exp_jaddr, exp_maddr, exp_mwdata;
    reg_addr_t exp_waddr;
    wmask_t    exp_mask;
    logic [31:0] lfsr;

    ex_stage DUT (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .valid_i       (valid_i),
        .inst_i        (inst_i),
        .pc_i          (pc_i),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .base_addr_i   (base_addr_i),
        .offset_addr_i (offset_addr_i),
        .rd_addr_i     (rd_addr_i),
        .valid_o       (valid_o),
        .pc_o          (pc_o),
        .rd_wdata_o    (rd_wdata_o),
        .rd_waddr_o    (rd_waddr_o),
        .reg_wen_o     (reg_wen_o),
        .jump_en_o     (jump_en_o),
        .jump_addr_o   (jump_addr_o),
        .mem_ren_o     (mem_ren_o),
        .mem_wen_o     (mem_wen_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_wmask_o   (mem_wmask_o)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    initial begin
        arst_n_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n_i = 1'b1;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED time=%0t signal=%s got=0x%0h expected=0x%0h",
                                     $time, name, got, exp));
        end
    endtask

    function automatic xlen_t int_result(input funct3_t f3, input logic alt, input logic word,
                                         input xlen_t a, input xlen_t b);
        logic [31:0] w;
        xlen_t       r;
        w = '0;
        r = '0;
        if (word) begin
            case (f3)
                F3_ADD:  w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
                F3_SLL:  w = a[31:0] << b[4:0];
                default: begin
                    if (alt)
                        w = $signed(a[31:0]) >>> b[4:0];
                    else
                        w = a[31:0] >> b[4:0];
                end
            endcase
            return {{32{w[31]}}, w};  // word result sign-extended from bit 31
        end
        case (f3)
            F3_ADD:  r = alt ? a - b : a + b;
            F3_SLL:  r = a << b[5:0];
            F3_SLT:  r = xlen_t'($signed(a) < $signed(b));
            F3_SLTU: r = xlen_t'(a < b);
            F3_XOR:  r = a ^ b;
            F3_SR: begin
                if (alt)
                    r = $signed(a) >>> b[5:0];
                else
                    r = a >> b[5:0];
            end
            F3_OR:   r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(input funct3_t f3, input xlen_t a, input xlen_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic r_funct7_ok(input funct3_t f3, input funct7_t f7);
        return (f7 == F7_BASE) || ((f7 == F7_ALT) && ((f3 == F3_ADD) || (f3 == F3_SR)));
    endfunction

    function automatic logic word_f3_ok(input funct3_t f3);
        return (f3 == F3_ADD) || (f3 == F3_SLL) || (f3 == F3_SR);
    endfunction

    task automatic drive_random();
        opcode_t opc;
        funct7_t f7;
        valid_i = (rand_bits(2) != 0);  // high 3 times in 4
        opc     = OPC_TABLE[rand_bits(4) % 12];
        case (rand_bits(2))
            0:       f7 = F7_BASE;
            1:       f7 = F7_ALT;
            default: f7 = funct7_t'(rand_bits(7));
        endcase
        inst_i        = {f7, 18'(rand_bits(18)), opc};
        pc_i          = rand_bits(64);
        op1_i         = rand_bits(64);
        op2_i         = (rand_bits(3) == 0) ? op1_i : rand_bits(64);
        base_addr_i   = rand_bits(64);
        offset_addr_i = rand_bits(64);
        rd_addr_i     = reg_addr_t'(rand_bits(5));
        if ((opc == OPC_JAL) || (opc == OPC_JALR)) begin
            op1_i = pc_i;  // link operands
            op2_i = 64'd4;
        end
    endtask

    task automatic predict();
        funct3_t f3;
        funct7_t f7;
        logic    writes;
        logic    load;
        logic    store;
        logic    jump;
        xlen_t   res;
        xlen_t   agu;
        f3     = inst_i[14:12];
        f7     = inst_i[31:25];
        agu    = base_addr_i + offset_addr_i;
        res    = op1_i + op2_i;  // auipc and link
        writes = 1'b0;
        load   = 1'b0;
        store  = 1'b0;
        jump   = 1'b0;
        case (opcode_t'(inst_i[6:0]))
            OPC_OP_IMM: begin
                writes = 1'b1;
                res    = int_result(f3, (f3 == F3_SR) && f7[5], 1'b0, op1_i, op2_i);
            end
            OPC_OP_IMM_W: begin
                writes = word_f3_ok(f3);
                res    = int_result(f3, (f3 == F3_SR) && f7[5], 1'b1, op1_i, op2_i);
            end
            OPC_OP: begin
                writes = r_funct7_ok(f3, f7);
                res    = int_result(f3, f7[5], 1'b0, op1_i, op2_i);
            end
            OPC_OP_W: begin
                writes = r_funct7_ok(f3, f7) && word_f3_ok(f3);
                res    = int_result(f3, f7[5], 1'b1, op1_i, op2_i);
            end
            OPC_LUI: begin
                writes = 1'b1;
                res    = op2_i;
            end
            OPC_AUIPC: writes = 1'b1;
            OPC_JAL, OPC_JALR: begin
                writes = 1'b1;
                jump   = 1'b1;
            end
            OPC_BRANCH: jump = branch_taken(f3, op1_i, op2_i);
            OPC_LOAD: begin
                load   = (f3 != 3'b111);
                writes = load;
            end
            OPC_STORE: store = (f3 <= F3_SD);
            default: ;
        endcase
        exp_valid  = valid_i;
        exp_wen    = valid_i && writes;
        exp_jen    = valid_i && jump;
        exp_ren    = valid_i && load;
        exp_men    = valid_i && store;
        exp_mask   = exp_men ? wmask_t'((1 << (1 << f3)) - 1) : '0;  // 1, 2, 4 or 8 lanes
        exp_pc     = pc_i;
        exp_wdata  = (writes && !load) ? res : '0;
        exp_waddr  = writes ? rd_addr_i : '0;
        exp_jaddr  = jump ? agu : '0;
        exp_maddr  = (load || store) ? agu : '0;
        exp_mwdata = store ? (op2_i & ((64'd1 << (8 << f3)) - 64'd1)) : '0;
    endtask

    task automatic check_outputs();
        compare("valid_o", valid_o, exp_valid);
        compare("reg_wen_o", reg_wen_o, exp_wen);
        compare("jump_en_o", jump_en_o, exp_jen);
        compare("mem_ren_o", mem_ren_o, exp_ren);
        compare("mem_wen_o", mem_wen_o, exp_men);
        compare("mem_wmask_o", mem_wmask_o, exp_mask);
        if (exp_valid) begin  // payload is don't care on idle cycles
            compare("pc_o", pc_o, exp_pc);
            compare("rd_wdata_o", rd_wdata_o, exp_wdata);
            compare("rd_waddr_o", rd_waddr_o, exp_waddr);
            compare("jump_addr_o", jump_addr_o, exp_jaddr);
            compare("mem_addr_o", mem_addr_o, exp_maddr);
            compare("mem_wdata_o", mem_wdata_o, exp_mwdata);
        end
    endtask

    initial begin
        int waited;
        lfsr          = SEED;
        valid_i       = 1'b0;
        inst_i        = '0;
        pc_i          = '0;
        op1_i         = '0;
        op2_i         = '0;
        base_addr_i   = '0;
        offset_addr_i = '0;
        rd_addr_i     = '0;
        predict();  // idle state expected right after reset
        waited = 0;
        while (arst_n_i !== 1'b1) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                report_failure("timeout waiting for reset release");
        end
        repeat (NUM_CYCLES) begin
            @(posedge clk);
            #1;
            check_outputs();
            drive_random();
            predict();
        end
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            check_outputs();
            valid_i = 1'b0;
            predict();
            waited++;
            if (waited > WAIT_LIMIT)
                report_failure("timeout while draining the last instruction");
        end while (valid_o || exp_valid);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- tb.f
hdl/ex_pkg.sv
hdl/ex_decode.sv
hdl/ex_alu.sv
hdl/ex_branch.sv
hdl/ex_lsu_req.sv
hdl/ex_stage.sv
tb/ex_stage_asserts.sv
tb/tb_ex_stage.sv
